//--- capture/capture_buffer.sv
// DEPTH must be a power of two, 4..1024; one record per arm, starting at the trigger sample
`timescale 1ns/1ns

module capture_buffer import scope_pkg::*; #(
	parameter int DEPTH = 16
) (
	input  logic                     lb_clk,
	input  logic                     rst_i,
	input  logic                     arm_i,
	input  logic [SAMPLE_W-1:0]      samp_i,
	input  logic                     samp_valid_i,
	input  logic                     trig_i,
	input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
	output logic [SAMPLE_W-1:0]      rd_data_o,
	output logic                     armed_o,
	output logic                     done_o
);

	localparam int AW = $clog2(DEPTH);

	scope_state_t        state;
	logic [AW-1:0]       wr_addr;
	logic                wr_en;
	logic [SAMPLE_W-1:0] mem [DEPTH];

	assign wr_en = samp_valid_i &&
		((state == CAP_ARMED && trig_i) || state == CAP_FILLING);

	assign armed_o = (state == CAP_ARMED) || (state == CAP_FILLING);
	assign done_o = (state == CAP_DONE);

	always_ff @(posedge lb_clk) begin
		if (rst_i) begin
			state <= CAP_IDLE;
			wr_addr <= '0;
		end else begin
			// address wraps back to 0 at the end of a record
			if (wr_en)
				wr_addr <= wr_addr + 1'b1;
			case (state)
				CAP_IDLE, CAP_DONE: begin
					if (arm_i)
						state <= CAP_ARMED;
				end
				CAP_ARMED: begin
					if (wr_en)
						state <= CAP_FILLING;
				end
				CAP_FILLING: begin
					if (wr_en && wr_addr == AW'(DEPTH - 1))
						state <= CAP_DONE;
				end
				default: state <= CAP_IDLE;
			endcase
		end
	end

	// record memory, registered read
	always_ff @(posedge lb_clk) begin
		if (wr_en)
			mem[wr_addr] <= samp_i;
		rd_data_o <= mem[rd_addr_i];
	end

	// outside a fill the write pointer never moves
	assert property (@(posedge lb_clk) disable iff (rst_i)
		!(state == CAP_FILLING || (state == CAP_ARMED && trig_i)) |=> $stable(wr_addr));

endmodule

//--- capture/trigger_detect.sv
// rising crossing only, signed compare; no crossing on the first sample after a channel change
`timescale 1ns/1ns

module trigger_detect import scope_pkg::*; (
	input  logic                       lb_clk,
	input  logic                       rst_i,
	input  logic [ADC_W-1:0]           adc_word_i,
	input  logic                       adc_valid_i,
	input  logic [CHAN_W-1:0]          chan_i,
	input  logic signed [SAMPLE_W-1:0] level_i,
	output logic signed [SAMPLE_W-1:0] samp_o,
	output logic                       samp_valid_o,
	output logic                       trig_o
);

	logic signed [SAMPLE_W-1:0] cur;
	logic signed [SAMPLE_W-1:0] prev;
	logic                       hist_valid;
	logic [CHAN_W-1:0]          chan_q;
	logic                       chan_change;
	logic                       crossing;

	assign cur = adc_word_i[chan_i*SAMPLE_W +: SAMPLE_W];
	assign chan_change = (chan_i != chan_q);
	assign crossing = hist_valid && !chan_change && (prev < level_i) && (cur >= level_i);

	always_ff @(posedge lb_clk) begin
		if (rst_i) begin
			samp_valid_o <= 1'b0;
			trig_o <= 1'b0;
			hist_valid <= 1'b0;
			chan_q <= '0;
		end else begin
			samp_valid_o <= adc_valid_i;
			trig_o <= adc_valid_i && crossing;
			chan_q <= chan_i;
			// new channel restarts history with its own sample, if any
			if (chan_change)
				hist_valid <= adc_valid_i;
			else if (adc_valid_i)
				hist_valid <= 1'b1;
		end
	end

	always_ff @(posedge lb_clk) begin
		if (adc_valid_i) begin
			samp_o <= cur;
			prev <= cur;
		end
	end

	// a trigger always travels with its own sample
	assert property (@(posedge lb_clk) disable iff (rst_i)
		trig_o |-> samp_valid_o);

endmodule

//--- common/host_pkg.sv
// host byte protocol: one opcode byte, then its arguments; unknown opcodes are dropped
package host_pkg;

	// host port word
	localparam int BYTE_W = 8;

	typedef enum logic [BYTE_W-1:0] {
		OP_SET_CHAN  = 8'h01,
		OP_SET_LEVEL = 8'h02,
		OP_ARM       = 8'h03,
		OP_READ      = 8'h04
	} host_op_t;

	// argument bytes after each opcode, level goes high byte first
	localparam int ARGS_SET_CHAN  = 1;
	localparam int ARGS_SET_LEVEL = 2;

	// wide enough for the longest argument count
	localparam int ARG_CNT_W = 2;

endpackage

//--- common/scope_pkg.sv
// widths fixed by one ADC chip word: four signed 16-bit channels, channel k in bits 16k+15:16k
package scope_pkg;

	// channels carried in one deserialized ADC word
	localparam int N_CHAN = 4;

	// one signed sample
	localparam int SAMPLE_W = 16;

	// whole ADC word
	localparam int ADC_W = N_CHAN * SAMPLE_W;

	// channel index
	localparam int CHAN_W = $clog2(N_CHAN);

	// capture sequence, one record per arm
	typedef enum logic [1:0] {
		CAP_IDLE,
		CAP_ARMED,
		CAP_FILLING,
		CAP_DONE
	} scope_state_t;

endpackage

//--- host/host_cmd_decode.sv
// rx_read_o pulses at most every other cycle; settings apply the cycle after their last byte
`timescale 1ns/1ns

module host_cmd_decode import host_pkg::*, scope_pkg::*; (
	input  logic                       lb_clk,
	input  logic                       rst_i,
	input  logic [BYTE_W-1:0]          rx_word_i,
	input  logic                       rx_available_i,
	output logic                       rx_read_o,
	output logic [CHAN_W-1:0]          chan_o,
	output logic signed [SAMPLE_W-1:0] level_o,
	output logic                       arm_o,
	output logic                       read_o
);

	typedef enum logic {
		DEC_OPCODE,
		DEC_ARGS
	} dec_state_t;

	dec_state_t             state;
	host_op_t               op;
	logic [ARG_CNT_W-1:0]   pend;
	logic [BYTE_W-1:0]      level_hi;

	always_ff @(posedge lb_clk) begin
		arm_o <= 1'b0;
		read_o <= 1'b0;
		if (rst_i) begin
			rx_read_o <= 1'b0;
			state <= DEC_OPCODE;
			op <= OP_SET_CHAN;
			pend <= '0;
			chan_o <= '0;
			level_o <= '0;
		end else begin
			// skip a cycle after each read so the transport can update available
			rx_read_o <= rx_available_i && !rx_read_o;
			if (rx_read_o) begin
				case (state)
					DEC_OPCODE: begin
						case (host_op_t'(rx_word_i))
							OP_SET_CHAN: begin
								op <= OP_SET_CHAN;
								pend <= ARG_CNT_W'(ARGS_SET_CHAN);
								state <= DEC_ARGS;
							end
							OP_SET_LEVEL: begin
								op <= OP_SET_LEVEL;
								pend <= ARG_CNT_W'(ARGS_SET_LEVEL);
								state <= DEC_ARGS;
							end
							OP_ARM: begin
								arm_o <= 1'b1;
							end
							OP_READ: begin
								read_o <= 1'b1;
							end
							default: begin
								// unknown byte, dropped
							end
						endcase
					end
					DEC_ARGS: begin
						pend <= pend - 1'b1;
						if (pend == ARG_CNT_W'(1))
							state <= DEC_OPCODE;
						if (op == OP_SET_CHAN) begin
							chan_o <= rx_word_i[CHAN_W-1:0];
						end else if (pend == ARG_CNT_W'(ARGS_SET_LEVEL)) begin
							level_hi <= rx_word_i;
						end else begin
							level_o <= {level_hi, rx_word_i};
						end
					end
					default: begin
						state <= DEC_OPCODE;
					end
				endcase
			end
		end
	end

	// a byte is only consumed while the transport still offers it
	assert property (@(posedge lb_clk) disable iff (rst_i)
		rx_read_o |-> rx_available_i);

endmodule

//--- host/readout_stream.sv
// dump starts only when a record is done; bytes go out high first, pacing follows tx_available_i
`timescale 1ns/1ns

module readout_stream import scope_pkg::*, host_pkg::*; #(
	parameter int DEPTH = 16
) (
	input  logic                    lb_clk,
	input  logic                    rst_i,
	input  logic                    start_i,
	input  logic                    done_i,
	output logic [$clog2(DEPTH)-1:0] rd_addr_o,
	input  logic [SAMPLE_W-1:0]     rd_data_i,
	input  logic                    tx_available_i,
	output logic [BYTE_W-1:0]       tx_word_o,
	output logic                    tx_write_o
);

	localparam int AW = $clog2(DEPTH);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_WAIT,
		RD_SEND
	} rd_state_t;

	rd_state_t state;
	logic      half;

	// low byte once the high one has gone
	assign tx_word_o = half ? rd_data_i[BYTE_W-1:0] : rd_data_i[SAMPLE_W-1 -: BYTE_W];
	assign tx_write_o = (state == RD_SEND) && tx_available_i;

	always_ff @(posedge lb_clk) begin
		if (rst_i) begin
			state <= RD_IDLE;
			rd_addr_o <= '0;
			half <= 1'b0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (start_i && done_i) begin
						rd_addr_o <= '0;
						half <= 1'b0;
						state <= RD_WAIT;
					end
				end
				// RAM output registers the new address here
				RD_WAIT: state <= RD_SEND;
				RD_SEND: begin
					if (tx_write_o) begin
						half <= !half;
						if (half) begin
							if (rd_addr_o == AW'(DEPTH - 1)) begin
								state <= RD_IDLE;
							end else begin
								rd_addr_o <= rd_addr_o + 1'b1;
								state <= RD_WAIT;
							end
						end
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// only send with room, and never before the RAM has seen the address
	assert property (@(posedge lb_clk) disable iff (rst_i)
		tx_write_o |-> tx_available_i && $stable(rd_addr_o));

endmodule

//--- logic/scope_app_top.sv
// single clock lb_clk; ADC samples must already be aligned and deserialized
`timescale 1ns/1ns

module scope_app_top import scope_pkg::*, host_pkg::*; #(
	parameter int DEPTH = 16
) (
	input  logic              lb_clk,
	input  logic              rst_i,
	input  logic [ADC_W-1:0]  adc_word_i,
	input  logic              adc_valid_i,
	input  logic [BYTE_W-1:0] rx_word_i,
	input  logic              rx_available_i,
	output logic              rx_read_o,
	output logic [BYTE_W-1:0] tx_word_o,
	output logic              tx_write_o,
	input  logic              tx_available_i,
	output logic              armed_o,
	output logic              done_o
);

	localparam int AW = $clog2(DEPTH);

	logic [CHAN_W-1:0]          chan_sel;
	logic signed [SAMPLE_W-1:0] trig_level;
	logic                       arm_p;
	logic                       read_p;
	logic signed [SAMPLE_W-1:0] samp;
	logic                       samp_valid;
	logic                       trig;
	logic [AW-1:0]              rd_addr;
	logic [SAMPLE_W-1:0]        rd_data;

	host_cmd_decode host_cmd_decode_i (
		.lb_clk(lb_clk), .rst_i(rst_i),
		.rx_word_i(rx_word_i), .rx_available_i(rx_available_i), .rx_read_o(rx_read_o),
		.chan_o(chan_sel), .level_o(trig_level), .arm_o(arm_p), .read_o(read_p)
	);

	trigger_detect trigger_detect_i (
		.lb_clk(lb_clk), .rst_i(rst_i),
		.adc_word_i(adc_word_i), .adc_valid_i(adc_valid_i),
		.chan_i(chan_sel), .level_i(trig_level),
		.samp_o(samp), .samp_valid_o(samp_valid), .trig_o(trig)
	);

	capture_buffer #(.DEPTH(DEPTH)) capture_buffer_i (
		.lb_clk(lb_clk), .rst_i(rst_i), .arm_i(arm_p),
		.samp_i(samp), .samp_valid_i(samp_valid), .trig_i(trig),
		.rd_addr_i(rd_addr), .rd_data_o(rd_data),
		.armed_o(armed_o), .done_o(done_o)
	);

	readout_stream #(.DEPTH(DEPTH)) readout_stream_i (
		.lb_clk(lb_clk), .rst_i(rst_i), .start_i(read_p), .done_i(done_o),
		.rd_addr_o(rd_addr), .rd_data_i(rd_data),
		.tx_available_i(tx_available_i), .tx_word_o(tx_word_o), .tx_write_o(tx_write_o)
	);

endmodule

//--- src.f
common/scope_pkg.sv
common/host_pkg.sv
host/host_cmd_decode.sv
host/readout_stream.sv
capture/trigger_detect.sv
capture/capture_buffer.sv
logic/scope_app_top.sv
test/scope_app_tb.sv

//--- test/scope_app_tb.sv
// DEPTH 16 record; ADC strobes pause while a case configures, so arming never overlaps a sample
`timescale 1ns/1ns

module scope_app_tb
	import host_pkg::*, scope_pkg::*;
();

	localparam int DEPTH = 16;
	localparam int N_CASES = 5;
	localparam int MAX_SAMPLES = 64;
	localparam int WATCH_CYCLES = 200;
	localparam logic [31:0] SEED = 32'ha5b4_8add;

	logic              lb_clk;
	logic              rst_i;
	logic [ADC_W-1:0]  adc_word_i;
	logic              adc_valid_i;
	logic [BYTE_W-1:0] rx_word_i;
	logic              rx_available_i;
	logic              rx_read_o;
	logic [BYTE_W-1:0] tx_word_o;
	logic              tx_write_o;
	logic              tx_available_i;
	logic              armed_o;
	logic              done_o;

	// name, channel, level, ramp start, ramp step
	string case_name [N_CASES] = '{"ch0_pos", "ch2_neg_level", "ch3_never",
		"ch1_rearm", "ch1_same_chan"};
	logic [CHAN_W-1:0] case_chan [N_CASES] = '{2'd0, 2'd2, 2'd3, 2'd1, 2'd1};
	logic signed [SAMPLE_W-1:0] case_level [N_CASES] =
		'{16'sd100, -16'sd300, 16'sd20000, 16'sd0, 16'sd200};
	logic signed [SAMPLE_W-1:0] case_start [N_CASES] =
		'{-16'sd200, -16'sd1000, 16'sd0, -16'sd64, -16'sd100};
	logic signed [SAMPLE_W-1:0] case_step [N_CASES] =
		'{16'sd25, 16'sd50, 16'sd10, 16'sd8, 16'sd30};

	logic [31:0]                lcg_tx;
	logic [31:0]                lcg_adc;
	logic [BYTE_W-1:0]          tx_q [$];
	logic [SAMPLE_W-1:0]        exp_q [$];
	logic signed [SAMPLE_W-1:0] model_prev;
	logic                       model_hist;
	logic [CHAN_W-1:0]          model_chan;
	logic signed [SAMPLE_W-1:0] model_level;

	scope_app_top #(.DEPTH(DEPTH)) scope_app_top_i (
		.lb_clk(lb_clk), .rst_i(rst_i),
		.adc_word_i(adc_word_i), .adc_valid_i(adc_valid_i),
		.rx_word_i(rx_word_i), .rx_available_i(rx_available_i), .rx_read_o(rx_read_o),
		.tx_word_o(tx_word_o), .tx_write_o(tx_write_o), .tx_available_i(tx_available_i),
		.armed_o(armed_o), .done_o(done_o)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error %s: expected %0h, actual %0h", name, expected, actual);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Verification failed");
		$fatal(1, "stopped on timeout");
	endtask

	initial begin
		lb_clk = 1'b0;
		forever #50 lb_clk = ~lb_clk;
	end

	// transport side: random room, every written byte collected
	always @(posedge lb_clk) begin
		if (tx_write_o)
			tx_q.push_back(tx_word_o);
		lcg_tx = lcg_next(lcg_tx);
		tx_available_i <= (lcg_tx[17:16] != 2'b00);
	end

	task automatic send_byte(input logic [BYTE_W-1:0] b);
		int n;
		@(posedge lb_clk);
		rx_word_i <= b;
		rx_available_i <= 1'b1;
		n = 0;
		do begin
			@(posedge lb_clk);
			n++;
			if (n > 20)
				fail_timeout("rx_read_o");
		end while (!rx_read_o);
		rx_available_i <= 1'b0;
	endtask

	// rising crossing on the selected channel opens the record
	task automatic model_sample(input logic signed [SAMPLE_W-1:0] v);
		if (exp_q.size() > 0 && exp_q.size() < DEPTH)
			exp_q.push_back(v);
		else if (exp_q.size() == 0 && model_hist && model_prev < model_level &&
			v >= model_level)
			exp_q.push_back(v);
		model_prev = v;
		model_hist = 1'b1;
	endtask

	task automatic configure(input int c);
		send_byte(OP_SET_CHAN);
		send_byte(BYTE_W'(case_chan[c]));
		if (case_chan[c] != model_chan)
			model_hist = 1'b0;
		model_chan = case_chan[c];
		// unknown opcodes between commands
		send_byte(8'h5a);
		send_byte(OP_SET_LEVEL);
		send_byte(case_level[c][15:8]);
		send_byte(case_level[c][7:0]);
		model_level = case_level[c];
		send_byte(8'hc3);
		send_byte(OP_ARM);
	endtask

	task automatic stream_ramp(input int c);
		logic signed [SAMPLE_W-1:0] ramp;
		logic [ADC_W-1:0]           w;
		int                         i;
		i = 0;
		ramp = case_start[c];
		while (i < MAX_SAMPLES && exp_q.size() < DEPTH) begin
			for (int k = 0; k < N_CHAN; k++) begin
				lcg_adc = lcg_next(lcg_adc);
				w[k*SAMPLE_W +: SAMPLE_W] = (k == case_chan[c]) ? ramp : ramp + lcg_adc[31:16];
			end
			model_sample(ramp);
			@(posedge lb_clk);
			adc_word_i <= w;
			adc_valid_i <= 1'b1;
			@(posedge lb_clk);
			adc_valid_i <= 1'b0;
			ramp = ramp + case_step[c];
			i++;
		end
	endtask

	task automatic read_and_compare(input int c);
		int n;
		tx_q.delete();
		send_byte(OP_READ);
		n = 0;
		while (tx_q.size() < 2 * DEPTH) begin
			@(posedge lb_clk);
			n++;
			if (n > 40 * DEPTH)
				fail_timeout("capture dump bytes");
		end
		// quiet tail exposes a duplicated byte
		repeat (50) @(posedge lb_clk);
		check_value($sformatf("%s byte count", case_name[c]), 2 * DEPTH, tx_q.size());
		for (int k = 0; k < DEPTH; k++) begin
			check_value($sformatf("%s sample %0d high", case_name[c], k),
				exp_q[k][15:8], tx_q[2*k]);
			check_value($sformatf("%s sample %0d low", case_name[c], k),
				exp_q[k][7:0], tx_q[2*k+1]);
		end
	endtask

	task automatic run_case(input int c);
		int n;
		exp_q.delete();
		configure(c);
		n = 0;
		while (!armed_o) begin
			@(posedge lb_clk);
			n++;
			if (n > 20)
				fail_timeout("armed_o");
		end
		check_value($sformatf("%s done after arm", case_name[c]), 0, done_o);
		stream_ramp(c);
		if (exp_q.size() == DEPTH) begin
			n = 0;
			while (!done_o) begin
				@(posedge lb_clk);
				n++;
				if (n > 20)
					fail_timeout("done_o");
			end
			read_and_compare(c);
		end else begin
			// no crossing, the record stays open
			for (n = 0; n < WATCH_CYCLES; n++) begin
				@(posedge lb_clk);
				check_value($sformatf("%s armed", case_name[c]), 1, armed_o);
				check_value($sformatf("%s done", case_name[c]), 0, done_o);
			end
		end
	endtask

	initial begin
		rst_i = 1'b1;
		adc_word_i = '0;
		adc_valid_i = 1'b0;
		rx_word_i = '0;
		rx_available_i = 1'b0;
		tx_available_i = 1'b0;
		lcg_tx = SEED;
		lcg_adc = SEED;
		model_prev = '0;
		model_hist = 1'b0;
		model_chan = '0;
		model_level = '0;
		repeat (5) @(posedge lb_clk);
		rst_i <= 1'b0;
		@(posedge lb_clk);
		check_value("reset armed_o", 0, armed_o);
		check_value("reset done_o", 0, done_o);
		check_value("reset rx_read_o", 0, rx_read_o);
		check_value("reset tx_write_o", 0, tx_write_o);
		// dump request with no record yet
		tx_q.delete();
		send_byte(OP_READ);
		repeat (WATCH_CYCLES) @(posedge lb_clk);
		check_value("read before capture", 0, tx_q.size());
		for (int c = 0; c < N_CASES; c++)
			run_case(c);
		$display("Verification passed");
		$finish;
	end

endmodule
